/* sources.f */
design/lc3b_types.sv
design/lc3b_ctrl_pkg.sv
design/issue_queue.sv
design/regfile.sv
design/stage_ID.sv
design/forward_unit.sv
design/alu.sv
design/stage_EX.sv
design/exec_core.sv
test/exec_core_tb.sv

/* test/exec_core_tb.sv */
`timescale 1ns/1ps

module exec_core_tb import lc3b_types::*; ();

    localparam int QUEUE_DEPTH = 4;

    logic     clk;
    logic     rst_n;
    logic     instr_valid;
    lc3b_word instr;
    lc3b_word pc;
    logic     instr_credit;
    logic     retire_valid;
    lc3b_reg  retire_dr;
    lc3b_word retire_data;
    lc3b_word retire_pc;

    logic [15:0] lfsr_state;
    int          credits;
    int          cycles;
    int          accept_cycle;
    int          last_retire_cycle;
    int          retire_count;
    int          errors;
    int          test_start_errors;
    int          tests_ok;
    int          tests_failed;
    logic        timed_out;
    string       test_name;
    lc3b_word    model_regs [8];
    lc3b_reg     exp_dr_q [$];
    lc3b_word    exp_data_q [$];
    lc3b_word    exp_pc_q [$];

    exec_core #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .pc           (pc),
        .instr_credit (instr_credit),
        .retire_valid (retire_valid),
        .retire_dr    (retire_dr),
        .retire_data  (retire_data),
        .retire_pc    (retire_pc)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    // Taps 16, 14, 13, 11.
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], next_bit()};
        end
        return v;
    endfunction

    function automatic lc3b_reg pick_reg(input logic narrow);
        if (narrow) return {2'b00, next_bit()}; // Only R0 and R1.
        return lc3b_reg'(rand_bits(3));
    endfunction

    function automatic int choose_kind(input int kind_set);
        int r;
        case (kind_set)
            0: begin
                r = int'(rand_bits(2));
                return (r == 3) ? 0 : r;
            end
            1: return next_bit() ? 3 : 4;
            2: begin
                r = int'(rand_bits(3));
                return (r > 4) ? r - 5 : r;
            end
            default: return int'(rand_bits(3)); // 5 to 7 are bubbles.
        endcase
    endfunction

    function automatic lc3b_word make_instr(input int kind, input logic narrow);
        lc3b_reg    dr;
        lc3b_reg    sr1;
        lc3b_reg    sr2;
        logic [3:0] op;
        lc3b_word   w;
        dr  = pick_reg(narrow);
        sr1 = pick_reg(narrow);
        sr2 = pick_reg(narrow);
        case (kind)
            0, 1: begin
                op = (kind == 0) ? 4'b0001 : 4'b0101;
                if (next_bit()) w = {op, dr, sr1, 1'b1, 5'(rand_bits(5))};
                else w = {op, dr, sr1, 3'b000, sr2};
            end
            2: w = {4'b1001, dr, sr1, 6'b111111};
            3: w = {4'b1101, dr, sr1, 2'(rand_bits(2)), 4'(rand_bits(4))};
            4: w = {4'b1110, dr, 9'(rand_bits(9))};
            default: begin
                op = 4'(rand_bits(4));
                if (op inside {4'b0001, 4'b0101, 4'b1001, 4'b1101, 4'b1110}) begin
                    op = op ^ 4'b0010;
                end
                w = {op, 12'(rand_bits(12))};
            end
        endcase
        return w;
    endfunction

    // In-order architectural model of the instruction subset.
    task automatic model_execute(input lc3b_word w, input lc3b_word pc_val);
        lc3b_word   a;
        lc3b_word   b;
        lc3b_word   res;
        logic [3:0] n;
        logic       writes;
        a      = model_regs[w[8:6]];
        b      = w[5] ? lc3b_word'($signed(w[4:0])) : model_regs[w[2:0]];
        n      = w[3:0];
        res    = '0;
        writes = 1'b1;
        case (w[15:12])
            4'b0001: res = a + b;
            4'b0101: res = a & b;
            4'b1001: res = ~a;
            4'b1101: begin
                if (!w[4]) begin
                    res = a << n;
                end else begin
                    res = a >> n;
                    if (w[5] && a[15]) res = res | ~(16'hffff >> n);
                end
            end
            4'b1110: res = pc_val + (lc3b_word'($signed(w[8:0])) << 1);
            default: writes = 1'b0;
        endcase
        if (writes) begin
            model_regs[w[11:9]] = res;
            exp_dr_q.push_back(w[11:9]);
            exp_data_q.push_back(res);
            exp_pc_q.push_back(pc_val);
        end
    endtask

    task automatic check_retire();
        lc3b_reg  exp_dr;
        lc3b_word exp_data;
        lc3b_word exp_pc;
        if (retire_valid) begin
            retire_count++;
            last_retire_cycle = cycles;
            assert (exp_dr_q.size() > 0) else begin
                $display("%s: the DUT retired an instruction that was never sent", test_name);
                errors++;
            end
            if (exp_dr_q.size() > 0) begin
                exp_dr   = exp_dr_q.pop_front();
                exp_data = exp_data_q.pop_front();
                exp_pc   = exp_pc_q.pop_front();
                assert (retire_dr == exp_dr) else begin
                    $display("FAIL %s dr: expected %0d actual %0d", test_name, exp_dr, retire_dr);
                    errors++;
                end
                assert (retire_data == exp_data) else begin
                    $display("FAIL %s data: expected %h actual %h",
                             test_name, exp_data, retire_data);
                    errors++;
                end
                assert (retire_pc == exp_pc) else begin
                    $display("FAIL %s pc: expected %h actual %h", test_name, exp_pc, retire_pc);
                    errors++;
                end
            end
        end
    endtask

    // Checks retire and takes credit back on the falling edge, then drives.
    task automatic tick(input logic want, input lc3b_word word, output logic sent);
        lc3b_word pc_val;
        @(negedge clk);
        check_retire();
        if (instr_credit) credits++;
        sent = want && (credits > 0);
        if (sent) begin
            pc_val = {15'(rand_bits(15)), 1'b0};
            credits--;
            model_execute(word, pc_val);
            accept_cycle = cycles + 1;
            instr_valid  = 1'b1;
            instr        = word;
            pc           = pc_val;
        end else begin
            instr_valid = 1'b0;
        end
        assert (credits >= 0 && credits <= QUEUE_DEPTH) else begin
            $display("%s: sender credit count left the range 0 to %0d", test_name, QUEUE_DEPTH);
            errors++;
        end
    endtask

    task automatic idle_cycle();
        logic sent;
        tick(1'b0, '0, sent);
    endtask

    task automatic drain(input int limit);
        int waited;
        waited = 0;
        while ((exp_dr_q.size() > 0 || credits != QUEUE_DEPTH) && waited < limit) begin
            idle_cycle();
            waited++;
        end
        if (exp_dr_q.size() > 0 || credits != QUEUE_DEPTH) begin
            $display("%s: timeout, an expected retire or credit never arrived", test_name);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic start_test(input string name);
        test_name         = name;
        test_start_errors = errors;
    endtask

    task automatic end_test();
        if (errors == test_start_errors) begin
            $display("Test %s: ok", test_name);
            tests_ok++;
        end else begin
            $display("Test %s: %0d errors", test_name, errors - test_start_errors);
            tests_failed++;
        end
    endtask

    task automatic run_test(input string name, input int count, input int kind_set,
                            input logic narrow, input logic dense);
        int       sent_total;
        int       waited;
        logic     want;
        logic     sent;
        lc3b_word word;
        start_test(name);
        sent_total = 0;
        waited     = 0;
        while (sent_total < count && waited < count * 10) begin
            want = dense || next_bit();
            word = make_instr(choose_kind(kind_set), narrow);
            tick(want, word, sent);
            if (sent) sent_total++;
            waited++;
        end
        if (sent_total < count) begin
            $display("%s: timeout, the sender ran out of credits", test_name);
            errors++;
            timed_out = 1'b1;
        end else begin
            drain(64);
        end
        end_test();
    endtask

    task automatic test_credit_flow();
        logic     sent;
        lc3b_word word;
        start_test("credit_flow");
        idle_cycle();
        assert (!instr_credit && !retire_valid) else begin
            $display("%s: credit or retire was high right after reset", test_name);
            errors++;
        end
        assert (credits == QUEUE_DEPTH) else begin
            $display("FAIL %s credits: expected %0d actual %0d", test_name, QUEUE_DEPTH, credits);
            errors++;
        end
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            word = make_instr(choose_kind(2), 1'b0);
            tick(1'b1, word, sent);
            assert (i >= 2 || !instr_credit) else begin
                $display("%s: a credit came back at burst entry %0d before any entry left",
                         test_name, i);
                errors++;
            end
        end
        drain(64);
        end_test();
    endtask

    task automatic test_latency();
        logic sent;
        int   waited;
        int   start_count;
        start_test("latency");
        repeat (3) idle_cycle();
        start_count = retire_count;
        tick(1'b1, make_instr(0, 1'b0), sent);
        waited = 0;
        while (retire_count == start_count && waited < 20) begin
            idle_cycle();
            waited++;
        end
        if (retire_count == start_count) begin
            $display("%s: timeout, the expected retire never arrived", test_name);
            errors++;
            timed_out = 1'b1;
        end else begin
            assert (last_retire_cycle - accept_cycle == 4) else begin
                $display("FAIL %s cycles: expected 4 actual %0d",
                         test_name, last_retire_cycle - accept_cycle);
                errors++;
            end
        end
        end_test();
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        pc           = '0;
        lfsr_state   = 16'd32872;
        credits      = QUEUE_DEPTH; // Sender starts full after reset.
        cycles       = 0;
        retire_count = 0;
        errors       = 0;
        tests_ok     = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        test_name    = "reset";
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_credit_flow();
        if (!timed_out) run_test("arith", 60, 0, 1'b0, 1'b0);
        if (!timed_out) run_test("shift_lea", 60, 1, 1'b0, 1'b0);
        if (!timed_out) run_test("forwarding", 80, 2, 1'b1, 1'b1);
        if (!timed_out) run_test("bubbles", 60, 3, 1'b1, 1'b1);
        if (!timed_out) test_latency();

        $display("Summary: %0d tests ok, %0d tests failed, %0d errors",
                 tests_ok, tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule : exec_core_tb

/* design/exec_core.sv */
`timescale 1ns/1ps

module exec_core import lc3b_types::*, lc3b_ctrl_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     instr_valid,
    input  lc3b_word instr,
    input  lc3b_word pc,
    output logic     instr_credit,
    output logic     retire_valid,
    output lc3b_reg  retire_dr,
    output lc3b_word retire_data,
    output lc3b_word retire_pc
);

    logic             head_valid;
    lc3b_word         head_instr;
    lc3b_word         head_pc;
    lc3b_reg          rd_addr_a;
    lc3b_reg          rd_addr_b;
    lc3b_word         rd_data_a;
    lc3b_word         rd_data_b;
    lc3b_control_word id_ctrl;
    lc3b_word         id_ir;
    lc3b_word         id_pc;
    lc3b_word         id_sr1;
    lc3b_word         id_sr2;
    lc3b_fwd_sel      fwd_a_sel;
    lc3b_fwd_sel      fwd_b_sel;
    lc3b_word         ex_alu;
    lc3b_word         ex_pcn;
    lc3b_control_word mem_ctrl;
    lc3b_word         mem_alu;
    lc3b_word         mem_pcn;
    lc3b_word         mem_pc;
    logic             wb_valid;
    logic             wb_writes;
    lc3b_reg          wb_dr;
    lc3b_word         wb_data;
    lc3b_word         wb_pc;

    issue_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .pc           (pc),
        .head_valid   (head_valid),
        .head_instr   (head_instr),
        .head_pc      (head_pc),
        .instr_credit (instr_credit)
    );

    regfile i_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (retire_valid),
        .wr_addr   (wb_dr),
        .wr_data   (wb_data),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    stage_ID i_id (
        .clk         (clk),
        .rst_n       (rst_n),
        .head_valid  (head_valid),
        .head_instr  (head_instr),
        .head_pc     (head_pc),
        .rd_data_a   (rd_data_a),
        .rd_data_b   (rd_data_b),
        .rd_addr_a   (rd_addr_a),
        .rd_addr_b   (rd_addr_b),
        .control_out (id_ctrl),
        .ir_out      (id_ir),
        .pc_out      (id_pc),
        .sr1_out     (id_sr1),
        .sr2_out     (id_sr2)
    );

    forward_unit i_fwd (
        .ex_sr1            (id_ctrl.sr1),
        .ex_sr2            (id_ctrl.sr2),
        .ex_uses_sr2       (id_ctrl.uses_sr2),
        .mem_valid         (mem_ctrl.valid),
        .mem_writes        (mem_ctrl.writes_reg),
        .mem_dr            (mem_ctrl.dr),
        .mem_is_lea        (mem_ctrl.result_pcn),
        .wb_valid          (wb_valid),
        .wb_writes         (wb_writes),
        .wb_dr             (wb_dr),
        .forward_A_mux_sel (fwd_a_sel),
        .forward_B_mux_sel (fwd_b_sel)
    );

    stage_EX i_ex (
        .control_in        (id_ctrl),
        .ir_in             (id_ir),
        .pc_in             (id_pc),
        .sr1_in            (id_sr1),
        .sr2_in            (id_sr2),
        .forward_A_mux_sel (fwd_a_sel),
        .forward_B_mux_sel (fwd_b_sel),
        .alu_EX_MEM        (mem_alu),
        .data_WB           (wb_data),
        .pcn_EX_MEM        (mem_pcn),
        .alu_out           (ex_alu),
        .pcn_out           (ex_pcn)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_ctrl  <= '0;
            wb_valid  <= 1'b0;
            wb_writes <= 1'b0;
        end else begin
            mem_ctrl  <= id_ctrl;
            wb_valid  <= mem_ctrl.valid;
            wb_writes <= mem_ctrl.writes_reg;
        end
    end

    // The memory slot only selects which result retires.
    always_ff @(posedge clk) begin
        mem_alu <= ex_alu;
        mem_pcn <= ex_pcn;
        mem_pc  <= id_pc;
        wb_dr   <= mem_ctrl.dr;
        wb_data <= mem_ctrl.result_pcn ? mem_pcn : mem_alu;
        wb_pc   <= mem_pc;
    end

    assign retire_valid = wb_valid && wb_writes;
    assign retire_dr    = wb_dr;
    assign retire_data  = wb_data;
    assign retire_pc    = wb_pc;

endmodule : exec_core

/* design/stage_EX.sv */
`timescale 1ns/1ps

module stage_EX import lc3b_types::*, lc3b_ctrl_pkg::*; (
    input  lc3b_control_word control_in,
    input  lc3b_word         ir_in,
    input  lc3b_word         pc_in,
    input  lc3b_word         sr1_in,
    input  lc3b_word         sr2_in,
    input  lc3b_fwd_sel      forward_A_mux_sel,
    input  lc3b_fwd_sel      forward_B_mux_sel,
    input  lc3b_word         alu_EX_MEM,
    input  lc3b_word         data_WB,
    input  lc3b_word         pcn_EX_MEM,
    output lc3b_word         alu_out,
    output lc3b_word         pcn_out
);

    lc3b_instr ir_view;
    lc3b_word  imm4;
    lc3b_word  imm5;
    lc3b_word  offset9;
    lc3b_word  b_mux_out;
    lc3b_word  fwd_a_out;
    lc3b_word  fwd_b_out;

    assign ir_view = ir_in;

    assign imm4    = {12'b0, ir_view.s.imm4};
    assign imm5    = {{11{ir_view.i.imm5[4]}}, ir_view.i.imm5};
    assign offset9 = {{6{ir_view.o.offset9[8]}}, ir_view.o.offset9, 1'b0}; // Word offset.

    assign pcn_out = pc_in + offset9;

    always_comb begin
        case (control_in.b_sel)
            BSEL_IMM4: b_mux_out = imm4;
            BSEL_IMM5: b_mux_out = imm5;
            default:   b_mux_out = sr2_in;
        endcase
    end

    always_comb begin
        case (forward_A_mux_sel)
            FWD_ALU: fwd_a_out = alu_EX_MEM;
            FWD_WB:  fwd_a_out = data_WB;
            FWD_PCN: fwd_a_out = pcn_EX_MEM;
            default: fwd_a_out = sr1_in;
        endcase
    end

    // Immediates pass through since B is only forwarded for sr2.
    always_comb begin
        case (forward_B_mux_sel)
            FWD_ALU: fwd_b_out = alu_EX_MEM;
            FWD_WB:  fwd_b_out = data_WB;
            FWD_PCN: fwd_b_out = pcn_EX_MEM;
            default: fwd_b_out = b_mux_out;
        endcase
    end

    alu general_alu (
        .aluop (control_in.alu_op),
        .a     (fwd_a_out),
        .b     (fwd_b_out),
        .f     (alu_out)
    );

endmodule : stage_EX

/* design/alu.sv */
`timescale 1ns/1ps

module alu import lc3b_types::*, lc3b_ctrl_pkg::*; (
    input  lc3b_aluop aluop,
    input  lc3b_word  a,
    input  lc3b_word  b,
    output lc3b_word  f
);

    logic [3:0] shamt;

    assign shamt = b[3:0];

    always_comb begin
        case (aluop)
            ALU_ADD: f = a + b;
            ALU_AND: f = a & b;
            ALU_NOT: f = ~a;
            ALU_SLL: f = a << shamt;
            ALU_SRL: f = a >> shamt;
            ALU_SRA: f = lc3b_word'($signed(a) >>> shamt); // Sign fill.
            default: f = '0;
        endcase
    end

endmodule : alu

/* design/forward_unit.sv */
`timescale 1ns/1ps

module forward_unit import lc3b_types::*, lc3b_ctrl_pkg::*; (
    input  lc3b_reg     ex_sr1,
    input  lc3b_reg     ex_sr2,
    input  logic        ex_uses_sr2,
    input  logic        mem_valid,
    input  logic        mem_writes,
    input  lc3b_reg     mem_dr,
    input  logic        mem_is_lea,
    input  logic        wb_valid,
    input  logic        wb_writes,
    input  lc3b_reg     wb_dr,
    output lc3b_fwd_sel forward_A_mux_sel,
    output lc3b_fwd_sel forward_B_mux_sel
);

    logic        mem_live;
    logic        wb_live;
    lc3b_fwd_sel mem_src;

    assign mem_live = mem_valid && mem_writes;
    assign wb_live  = wb_valid && wb_writes;
    assign mem_src  = mem_is_lea ? FWD_PCN : FWD_ALU;

    // The younger producer in EX/MEM takes priority.
    always_comb begin
        forward_A_mux_sel = FWD_REG;
        if (mem_live && (mem_dr == ex_sr1)) begin
            forward_A_mux_sel = mem_src;
        end else if (wb_live && (wb_dr == ex_sr1)) begin
            forward_A_mux_sel = FWD_WB;
        end

        forward_B_mux_sel = FWD_REG;
        if (ex_uses_sr2 && mem_live && (mem_dr == ex_sr2)) begin
            forward_B_mux_sel = mem_src;
        end else if (ex_uses_sr2 && wb_live && (wb_dr == ex_sr2)) begin
            forward_B_mux_sel = FWD_WB;
        end
    end

endmodule : forward_unit

/* design/stage_ID.sv */
`timescale 1ns/1ps

module stage_ID import lc3b_types::*, lc3b_ctrl_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             head_valid,
    input  lc3b_word         head_instr,
    input  lc3b_word         head_pc,
    input  lc3b_word         rd_data_a,
    input  lc3b_word         rd_data_b,
    output lc3b_reg          rd_addr_a,
    output lc3b_reg          rd_addr_b,
    output lc3b_control_word control_out,
    output lc3b_word         ir_out,
    output lc3b_word         pc_out,
    output lc3b_word         sr1_out,
    output lc3b_word         sr2_out
);

    lc3b_instr        inst;
    lc3b_control_word ctrl;
    logic             supported;

    assign inst = head_instr;

    assign rd_addr_a = inst.r.sr1;
    assign rd_addr_b = inst.r.sr2;

    always_comb begin
        ctrl            = '0;
        supported       = 1'b1;
        ctrl.dr         = inst.r.dr;
        ctrl.sr1        = inst.r.sr1;
        ctrl.sr2        = inst.r.sr2;
        ctrl.writes_reg = 1'b1;
        ctrl.b_sel      = inst.i.mode ? BSEL_IMM5 : BSEL_SR2;
        ctrl.uses_sr2   = !inst.i.mode;
        case (inst.r.opcode)
            OP_ADD: ctrl.alu_op = ALU_ADD;
            OP_AND: ctrl.alu_op = ALU_AND;
            OP_NOT: begin
                ctrl.alu_op   = ALU_NOT;
                ctrl.uses_sr2 = 1'b0;
            end
            OP_SHF: begin
                ctrl.b_sel    = BSEL_IMM4;
                ctrl.uses_sr2 = 1'b0;
                if (!inst.s.right) begin
                    ctrl.alu_op = ALU_SLL;
                end else if (inst.s.arith) begin
                    ctrl.alu_op = ALU_SRA;
                end else begin
                    ctrl.alu_op = ALU_SRL;
                end
            end
            OP_LEA: begin
                ctrl.result_pcn = 1'b1;
                ctrl.uses_sr2   = 1'b0;
            end
            default: begin
                supported       = 1'b0; // Travels on as a bubble.
                ctrl.writes_reg = 1'b0;
                ctrl.uses_sr2   = 1'b0;
            end
        endcase
        ctrl.valid = head_valid && supported;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            control_out <= '0;
        end else begin
            control_out <= ctrl;
        end
    end

    always_ff @(posedge clk) begin
        ir_out  <= head_instr;
        pc_out  <= head_pc;
        sr1_out <= rd_data_a;
        sr2_out <= rd_data_b;
    end

endmodule : stage_ID

/* design/regfile.sv */
`timescale 1ns/1ps

module regfile import lc3b_types::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wr_en,
    input  lc3b_reg  wr_addr,
    input  lc3b_word wr_data,
    input  lc3b_reg  rd_addr_a,
    input  lc3b_reg  rd_addr_b,
    output lc3b_word rd_data_a,
    output lc3b_word rd_data_b
);

    lc3b_word regs [8];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Write-through so decode sees the value retiring this cycle.
    assign rd_data_a = (wr_en && (wr_addr == rd_addr_a)) ? wr_data : regs[rd_addr_a];
    assign rd_data_b = (wr_en && (wr_addr == rd_addr_b)) ? wr_data : regs[rd_addr_b];

endmodule : regfile

/* design/issue_queue.sv */
`timescale 1ns/1ps

module issue_queue import lc3b_types::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     instr_valid,
    input  lc3b_word instr,
    input  lc3b_word pc,
    output logic     head_valid,
    output lc3b_word head_instr,
    output lc3b_word head_pc,
    output logic     instr_credit
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    lc3b_word         instr_mem [QUEUE_DEPTH];
    lc3b_word         pc_mem    [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;

    // Depth need not be a power of two.
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign pop = (count != '0); // Drains one entry per cycle.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            head_valid   <= 1'b0;
            instr_credit <= 1'b0;
        end else begin
            if (instr_valid) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            case ({instr_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            head_valid   <= pop;
            instr_credit <= pop; // One credit back per entry that left.
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            instr_mem[wr_ptr] <= instr;
            pc_mem[wr_ptr]    <= pc;
        end
        if (pop) begin
            head_instr <= instr_mem[rd_ptr];
            head_pc    <= pc_mem[rd_ptr];
        end
    end

endmodule : issue_queue

/* design/lc3b_ctrl_pkg.sv */
package lc3b_ctrl_pkg;

    import lc3b_types::*;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_AND,
        ALU_NOT,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } lc3b_aluop;

    // Second ALU operand before forwarding.
    typedef enum logic [1:0] {
        BSEL_SR2,
        BSEL_IMM4,
        BSEL_IMM5
    } lc3b_bsel;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_ALU = 2'd1,    // EX/MEM ALU result.
        FWD_WB  = 2'd2,
        FWD_PCN = 2'd3     // EX/MEM PC adder result.
    } lc3b_fwd_sel;

    typedef struct packed {
        lc3b_aluop alu_op;
        lc3b_bsel  b_sel;
        logic      result_pcn;  // Result comes from the PC adder.
        logic      uses_sr2;
        logic      writes_reg;
        lc3b_reg   dr;
        lc3b_reg   sr1;
        lc3b_reg   sr2;
        logic      valid;
    } lc3b_control_word;

endpackage : lc3b_ctrl_pkg

/* design/lc3b_types.sv */
package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;

    typedef enum logic [3:0] {
        OP_ADD = 4'b0001,
        OP_AND = 4'b0101,
        OP_NOT = 4'b1001,
        OP_SHF = 4'b1101,
        OP_LEA = 4'b1110
    } lc3b_opcode;

    typedef struct packed {
        lc3b_opcode  opcode;
        lc3b_reg     dr;
        lc3b_reg     sr1;
        logic        mode;    // Zero selects sr2.
        logic [1:0]  pad;
        lc3b_reg     sr2;
    } lc3b_instr_reg;

    typedef struct packed {
        lc3b_opcode  opcode;
        lc3b_reg     dr;
        lc3b_reg     sr1;
        logic        mode;
        logic [4:0]  imm5;
    } lc3b_instr_imm;

    typedef struct packed {
        lc3b_opcode  opcode;
        lc3b_reg     dr;
        lc3b_reg     sr1;
        logic        arith;   // Right shifts fill with the sign bit.
        logic        right;
        logic [3:0]  imm4;
    } lc3b_instr_shf;

    typedef struct packed {
        lc3b_opcode  opcode;
        lc3b_reg     dr;
        logic [8:0]  offset9;
    } lc3b_instr_off;

    typedef union packed {
        lc3b_instr_reg r;
        lc3b_instr_imm i;
        lc3b_instr_shf s;
        lc3b_instr_off o;
    } lc3b_instr;

endpackage : lc3b_types
